//--- rtl/hyper_cfg_pkg.sv
//##########################################################
// Register map and timing field widths of the HyperBus
// configuration block. Only the five timing fields used by
// the transfer sequencer are kept; chip ranges follow them.
//##########################################################

package hyper_cfg_pkg;

    // Base register indices, one data word each
    typedef enum int unsigned {
        REG_LATENCY     = 0,
        REG_LAT_ADD     = 1,
        REG_BURST_MAX   = 2,
        REG_RW_RECOVERY = 3,
        REG_CSH         = 4
    } cfg_reg_e;

    // Chip range registers start right after the base block
    localparam int unsigned NumBaseRegs = 5;

    // Field widths
    localparam int unsigned LatencyWidth  = 4;
    localparam int unsigned BurstWidth    = 8;
    localparam int unsigned RecoveryWidth = 4;
    localparam int unsigned CshWidth      = 4;

    // Reset values
    localparam logic [LatencyWidth-1:0]  RstLatency  = 4'd6;
    localparam logic                     RstLatAdd   = 1'b1;
    localparam logic [BurstWidth-1:0]    RstBurstMax = 8'd16;
    localparam logic [RecoveryWidth-1:0] RstRecovery = 4'd6;
    localparam logic [CshWidth-1:0]      RstCsh      = 4'd1;

endpackage

//--- rtl/hyper_xfer_pkg.sv
//##########################################################
// Transfer sequencer definitions. The command/address phase
// is six bytes at double data rate, so three clock cycles.
//##########################################################

package hyper_xfer_pkg;

    // Phase states of the transfer controller
    typedef enum logic [2:0] {
        IDLE    = 3'd0,
        CMD     = 3'd1,
        LATENCY = 3'd2,
        DATA    = 3'd3,
        HOLD    = 3'd4,
        RECOVER = 3'd5,
        FAIL    = 3'd6
    } xfer_state_e;

    // Command/address phase length in clock cycles
    localparam int unsigned CmdCycles = 3;

endpackage

//--- rtl/hyper_cfg_regs.sv
//##########################################################
// Configuration register file. RegDataWidth must be a power
// of two of at least 16. Writes are refused while a transfer
// is busy; reads are combinational, unmapped indices read 0.
//##########################################################

`timescale 1ns/1ps

module hyper_cfg_regs import hyper_cfg_pkg::*; #(
    parameter int unsigned             NumChips     = 2,
    parameter int unsigned             RegDataWidth = 32,
    parameter int unsigned             RegAddrWidth = 8,
    parameter logic [RegDataWidth-1:0] RstChipBase  = '0,
    parameter logic [RegDataWidth-1:0] RstChipSpace = 'h10000
) (
    input  logic                                 clk_i,
    input  logic                                 arst_n_i,

    input  logic                                 reg_valid_i,
    input  logic                                 reg_write_i,
    input  logic [RegAddrWidth-1:0]              reg_addr_i,
    input  logic [RegDataWidth-1:0]              reg_wdata_i,
    input  logic [RegDataWidth/8-1:0]            reg_wstrb_i,
    output logic [RegDataWidth-1:0]              reg_rdata_o,
    output logic                                 reg_ready_o,
    output logic                                 reg_error_o,

    input  logic                                 busy_i,

    output logic [LatencyWidth-1:0]              cfg_latency_o,
    output logic                                 cfg_lat_add_o,
    output logic [BurstWidth-1:0]                cfg_burst_max_o,
    output logic [RecoveryWidth-1:0]             cfg_recovery_o,
    output logic [CshWidth-1:0]                  cfg_csh_o,
    output logic [NumChips-1:0][RegDataWidth-1:0] chip_start_o,
    output logic [NumChips-1:0][RegDataWidth-1:0] chip_end_o
);

    localparam int unsigned StrbWidth = RegDataWidth / 8;
    localparam int unsigned ByteBits  = $clog2(StrbWidth);
    localparam int unsigned NumRegs   = NumBaseRegs + 2 * NumChips;

    logic [LatencyWidth-1:0]               latency_q;
    logic                                  lat_add_q;
    logic [BurstWidth-1:0]                 burst_max_q;
    logic [RecoveryWidth-1:0]              recovery_q;
    logic [CshWidth-1:0]                   csh_q;
    logic [NumChips-1:0][RegDataWidth-1:0] start_q;
    logic [NumChips-1:0][RegDataWidth-1:0] end_q;

    int unsigned             sel_reg;
    int unsigned             chip_off;
    int unsigned             chip_sel;
    logic                    sel_is_end;
    logic                    sel_mapped;
    logic                    wr_en;
    logic [RegDataWidth-1:0] wmask;
    logic [RegDataWidth-1:0] rd_word;
    logic [RegDataWidth-1:0] wr_word;

    // Byte address to word index
    assign sel_reg    = 32'(reg_addr_i >> ByteBits);
    assign sel_mapped = (sel_reg < NumRegs);

    // Chip registers come in start/end pairs
    assign chip_off   = sel_reg - NumBaseRegs;
    assign chip_sel   = chip_off >> 1;
    assign sel_is_end = chip_off[0];

    assign reg_ready_o = ~busy_i;
    assign reg_error_o = ~sel_mapped;

    for (genvar b = 0; b < StrbWidth; b++) begin : gen_wmask
        assign wmask[8*b +: 8] = {8{reg_wstrb_i[b]}};
    end

    // Read mux, narrow fields zero-extended
    always_comb begin : proc_read
        rd_word = '0;
        if (sel_mapped) begin
            case (sel_reg)
                REG_LATENCY:     rd_word = RegDataWidth'(latency_q);
                REG_LAT_ADD:     rd_word = RegDataWidth'(lat_add_q);
                REG_BURST_MAX:   rd_word = RegDataWidth'(burst_max_q);
                REG_RW_RECOVERY: rd_word = RegDataWidth'(recovery_q);
                REG_CSH:         rd_word = RegDataWidth'(csh_q);
                default:         rd_word = sel_is_end ? end_q[chip_sel] : start_q[chip_sel];
            endcase
        end
    end

    assign reg_rdata_o = rd_word;

    // Merge new bytes into the current value of the selected register
    assign wr_word = (rd_word & ~wmask) | (reg_wdata_i & wmask);
    assign wr_en   = reg_valid_i & reg_write_i & ~busy_i & sel_mapped;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            latency_q   <= RstLatency;
            lat_add_q   <= RstLatAdd;
            burst_max_q <= RstBurstMax;
            recovery_q  <= RstRecovery;
            csh_q       <= RstCsh;
            // Contiguous ranges from the base, end exclusive
            for (int i = 0; i < NumChips; i++) begin
                start_q[i] <= RstChipBase + RegDataWidth'(i) * RstChipSpace;
                end_q[i]   <= RstChipBase + RegDataWidth'(i + 1) * RstChipSpace;
            end
        end else if (wr_en) begin
            case (sel_reg)
                REG_LATENCY:     latency_q   <= wr_word[LatencyWidth-1:0];
                REG_LAT_ADD:     lat_add_q   <= wr_word[0];
                REG_BURST_MAX:   burst_max_q <= wr_word[BurstWidth-1:0];
                REG_RW_RECOVERY: recovery_q  <= wr_word[RecoveryWidth-1:0];
                REG_CSH:         csh_q       <= wr_word[CshWidth-1:0];
                default: begin
                    if (sel_is_end) begin
                        end_q[chip_sel] <= wr_word;
                    end else begin
                        start_q[chip_sel] <= wr_word;
                    end
                end
            endcase
        end
    end

    assign cfg_latency_o   = latency_q;
    assign cfg_lat_add_o   = lat_add_q;
    assign cfg_burst_max_o = burst_max_q;
    assign cfg_recovery_o  = recovery_q;
    assign cfg_csh_o       = csh_q;
    assign chip_start_o    = start_q;
    assign chip_end_o      = end_q;

endmodule

//--- rtl/hyper_chip_decoder.sv
//##########################################################
// Chip decoder, purely combinational. Ranges are
// [start, end); overlapping ranges resolve to the lowest
// chip index.
//##########################################################

`timescale 1ns/1ps

module hyper_chip_decoder #(
    parameter int unsigned NumChips     = 2,
    parameter int unsigned RegDataWidth = 32
) (
    input  logic [RegDataWidth-1:0]               addr_i,
    input  logic [NumChips-1:0][RegDataWidth-1:0] chip_start_i,
    input  logic [NumChips-1:0][RegDataWidth-1:0] chip_end_i,
    output logic [NumChips-1:0]                   chip_hit_o,
    output logic                                  no_hit_o
);

    logic [NumChips-1:0] match;

    // Raw range compare per chip
    for (genvar c = 0; c < NumChips; c++) begin : gen_match
        assign match[c] = (chip_start_i[c] <= addr_i) && (addr_i < chip_end_i[c]);
    end

    // Keep only the lowest matching chip
    always_comb begin : proc_prio
        logic found;
        found      = 1'b0;
        chip_hit_o = '0;
        for (int c = 0; c < NumChips; c++) begin
            if (match[c] && !found) begin
                chip_hit_o[c] = 1'b1;
                found         = 1'b1;
            end
        end
    end

    // An empty or inverted range never matches
    assign no_hit_o = ~|match;

endmodule

//--- rtl/hyper_xfer_ctrl.sv
//##########################################################
// Transfer phase sequencer. Requests are one-cycle strobes,
// taken only when idle. Timing fields are sampled at
// acceptance. Phases of zero length are skipped.
//##########################################################

`timescale 1ns/1ps

module hyper_xfer_ctrl import hyper_cfg_pkg::*, hyper_xfer_pkg::*; #(
    parameter int unsigned NumChips = 2
) (
    input  logic                     clk_i,
    input  logic                     arst_n_i,

    input  logic                     xfer_valid_i,
    input  logic [BurstWidth-1:0]    xfer_len_i,
    input  logic [NumChips-1:0]      chip_hit_i,
    input  logic                     no_hit_i,

    input  logic [LatencyWidth-1:0]  cfg_latency_i,
    input  logic                     cfg_lat_add_i,
    input  logic [BurstWidth-1:0]    cfg_burst_max_i,
    input  logic [RecoveryWidth-1:0] cfg_recovery_i,
    input  logic [CshWidth-1:0]      cfg_csh_i,

    output logic [NumChips-1:0]      cs_n_o,
    output logic                     xfer_busy_o,
    output logic                     xfer_done_o,
    output logic                     xfer_err_o
);

    // Burst length is the widest phase, doubled latency fits as well
    localparam int unsigned CntWidth = BurstWidth;

    xfer_state_e state_q, state_d;
    logic [CntWidth-1:0] cnt_q, cnt_d;
    logic                phase_end;
    logic                accept;
    logic                req_bad;
    logic                cs_active;

    // Values held for the running transfer
    logic [NumChips-1:0]      hit_q;
    logic [LatencyWidth:0]    lat_q;
    logic [BurstWidth-1:0]    len_q;
    logic [CshWidth-1:0]      csh_q;
    logic [RecoveryWidth-1:0] rec_q;

    assign accept    = (state_q == IDLE) && xfer_valid_i;
    assign req_bad   = no_hit_i || (xfer_len_i == '0) || (xfer_len_i > cfg_burst_max_i);
    assign phase_end = (cnt_q == '0);

    always_comb begin : proc_next_state
        state_d = state_q;
        case (state_q)
            IDLE:    if (xfer_valid_i) state_d = req_bad ? FAIL : CMD;
            CMD:     if (phase_end) state_d = (lat_q != '0) ? LATENCY : DATA;
            LATENCY: if (phase_end) state_d = DATA;
            DATA: begin
                if (phase_end) begin
                    if (csh_q != '0) begin
                        state_d = HOLD;
                    end else begin
                        state_d = (rec_q != '0) ? RECOVER : IDLE;
                    end
                end
            end
            HOLD:    if (phase_end) state_d = (rec_q != '0) ? RECOVER : IDLE;
            RECOVER: if (phase_end) state_d = IDLE;
            default: state_d = IDLE;
        endcase
    end

    // Counter loads the phase length minus one on every phase change
    always_comb begin : proc_next_cnt
        cnt_d = (state_q == IDLE) ? cnt_q : cnt_q - 1'b1;
        if (state_d != state_q) begin
            case (state_d)
                CMD:     cnt_d = CntWidth'(CmdCycles - 1);
                LATENCY: cnt_d = CntWidth'(lat_q) - 1'b1;
                DATA:    cnt_d = CntWidth'(len_q) - 1'b1;
                HOLD:    cnt_d = CntWidth'(csh_q) - 1'b1;
                RECOVER: cnt_d = CntWidth'(rec_q) - 1'b1;
                default: cnt_d = '0;
            endcase
        end
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q <= IDLE;
            cnt_q   <= '0;
        end else begin
            state_q <= state_d;
            cnt_q   <= cnt_d;
        end
    end

    always_ff @(posedge clk_i) begin
        if (accept) begin
            hit_q <= chip_hit_i;
            len_q <= xfer_len_i;
            csh_q <= cfg_csh_i;
            rec_q <= cfg_recovery_i;
            lat_q <= cfg_lat_add_i ? {cfg_latency_i, 1'b0} : {1'b0, cfg_latency_i};
        end
    end

    // Select held low through command, latency and data
    assign cs_active = (state_q == CMD) || (state_q == LATENCY) || (state_q == DATA);
    assign cs_n_o    = ~(hit_q & {NumChips{cs_active}});

    assign xfer_busy_o = (state_q != IDLE);
    assign xfer_err_o  = (state_q == FAIL);
    // Last busy cycle, FAIL included
    assign xfer_done_o = (state_q != IDLE) && (state_d == IDLE);

endmodule

//--- rtl/hyper_cfg_top.sv
//##########################################################
// HyperBus configuration and transfer sequencing top level.
// No PHY is attached; xfer_write_i is reserved for it.
// RegDataWidth must be a power of two of at least 16.
//##########################################################

`timescale 1ns/1ps

module hyper_cfg_top import hyper_cfg_pkg::*; #(
    parameter int unsigned             NumChips     = 2,
    parameter int unsigned             RegDataWidth = 32,
    parameter int unsigned             RegAddrWidth = 8,
    parameter logic [RegDataWidth-1:0] RstChipBase  = '0,
    parameter logic [RegDataWidth-1:0] RstChipSpace = 'h10000
) (
    input  logic                      clk_i,
    input  logic                      arst_n_i,

    input  logic                      reg_valid_i,
    input  logic                      reg_write_i,
    input  logic [RegAddrWidth-1:0]   reg_addr_i,
    input  logic [RegDataWidth-1:0]   reg_wdata_i,
    input  logic [RegDataWidth/8-1:0] reg_wstrb_i,
    output logic [RegDataWidth-1:0]   reg_rdata_o,
    output logic                      reg_ready_o,
    output logic                      reg_error_o,

    input  logic                      xfer_valid_i,
    input  logic                      xfer_write_i,
    input  logic [RegDataWidth-1:0]   xfer_addr_i,
    input  logic [BurstWidth-1:0]     xfer_len_i,

    output logic [NumChips-1:0]       cs_n_o,
    output logic                      xfer_busy_o,
    output logic                      xfer_done_o,
    output logic                      xfer_err_o
);

    logic [LatencyWidth-1:0]               cfg_latency;
    logic                                  cfg_lat_add;
    logic [BurstWidth-1:0]                 cfg_burst_max;
    logic [RecoveryWidth-1:0]              cfg_recovery;
    logic [CshWidth-1:0]                   cfg_csh;
    logic [NumChips-1:0][RegDataWidth-1:0] chip_start;
    logic [NumChips-1:0][RegDataWidth-1:0] chip_end;
    logic [NumChips-1:0]                   chip_hit;
    logic                                  no_hit;
    logic                                  xfer_busy;

    hyper_cfg_regs #(
        .NumChips     (NumChips),
        .RegDataWidth (RegDataWidth),
        .RegAddrWidth (RegAddrWidth),
        .RstChipBase  (RstChipBase),
        .RstChipSpace (RstChipSpace)
    ) u_regs (
        .clk_i           (clk_i),
        .arst_n_i        (arst_n_i),
        .reg_valid_i     (reg_valid_i),
        .reg_write_i     (reg_write_i),
        .reg_addr_i      (reg_addr_i),
        .reg_wdata_i     (reg_wdata_i),
        .reg_wstrb_i     (reg_wstrb_i),
        .reg_rdata_o     (reg_rdata_o),
        .reg_ready_o     (reg_ready_o),
        .reg_error_o     (reg_error_o),
        .busy_i          (xfer_busy),
        .cfg_latency_o   (cfg_latency),
        .cfg_lat_add_o   (cfg_lat_add),
        .cfg_burst_max_o (cfg_burst_max),
        .cfg_recovery_o  (cfg_recovery),
        .cfg_csh_o       (cfg_csh),
        .chip_start_o    (chip_start),
        .chip_end_o      (chip_end)
    );

    hyper_chip_decoder #(
        .NumChips     (NumChips),
        .RegDataWidth (RegDataWidth)
    ) u_decoder (
        .addr_i       (xfer_addr_i),
        .chip_start_i (chip_start),
        .chip_end_i   (chip_end),
        .chip_hit_o   (chip_hit),
        .no_hit_o     (no_hit)
    );

    hyper_xfer_ctrl #(
        .NumChips (NumChips)
    ) u_xfer_ctrl (
        .clk_i           (clk_i),
        .arst_n_i        (arst_n_i),
        .xfer_valid_i    (xfer_valid_i),
        .xfer_len_i      (xfer_len_i),
        .chip_hit_i      (chip_hit),
        .no_hit_i        (no_hit),
        .cfg_latency_i   (cfg_latency),
        .cfg_lat_add_i   (cfg_lat_add),
        .cfg_burst_max_i (cfg_burst_max),
        .cfg_recovery_i  (cfg_recovery),
        .cfg_csh_i       (cfg_csh),
        .cs_n_o          (cs_n_o),
        .xfer_busy_o     (xfer_busy),
        .xfer_done_o     (xfer_done_o),
        .xfer_err_o      (xfer_err_o)
    );

    assign xfer_busy_o = xfer_busy;

endmodule

//--- dv/tb_hyper_cfg.sv
//##########################################################
// Testbench for the HyperBus configuration top level with
// two chips and 32-bit registers. Timing is checked by
// concurrent assertions against a register model.
//##########################################################

`timescale 1ns/1ps

module tb_hyper_cfg import hyper_cfg_pkg::*, hyper_xfer_pkg::*;;

    localparam int unsigned NumChips  = 2;
    localparam int unsigned NumRegs   = NumBaseRegs + 2 * NumChips;
    localparam int          MaxCycles = 20000;
    localparam int          XferWait  = 400;
    localparam int          RegWait   = 400;

    logic                clk;
    logic                arst_n;
    logic                reg_valid;
    logic                reg_write;
    logic [7:0]          reg_addr;
    logic [31:0]         reg_wdata;
    logic [3:0]          reg_wstrb;
    logic [31:0]         reg_rdata;
    logic                reg_ready;
    logic                reg_error;
    logic                xfer_valid;
    logic                xfer_write;
    logic [31:0]         xfer_addr;
    logic [7:0]          xfer_len;
    logic [NumChips-1:0] cs_n;
    logic                xfer_busy;
    logic                xfer_done;
    logic                xfer_err;

    // Reference model and expected timing of the current transfer
    logic [31:0]         model_regs [NumRegs];
    logic [NumChips-1:0] exp_hit;
    logic                exp_fail;
    int                  exp_cs;
    int                  exp_busy;
    int                  cs_cnt;
    int                  cs_seen;
    int                  busy_cnt;
    int                  cycle_cnt;
    int                  assert_errs;
    int                  timeout_errs;
    logic                cs_low;

    hyper_cfg_top #(
        .NumChips     (NumChips),
        .RegDataWidth (32),
        .RegAddrWidth (8),
        .RstChipBase  (32'h0),
        .RstChipSpace (32'h10000)
    ) UUT (
        .clk_i        (clk),
        .arst_n_i     (arst_n),
        .reg_valid_i  (reg_valid),
        .reg_write_i  (reg_write),
        .reg_addr_i   (reg_addr),
        .reg_wdata_i  (reg_wdata),
        .reg_wstrb_i  (reg_wstrb),
        .reg_rdata_o  (reg_rdata),
        .reg_ready_o  (reg_ready),
        .reg_error_o  (reg_error),
        .xfer_valid_i (xfer_valid),
        .xfer_write_i (xfer_write),
        .xfer_addr_i  (xfer_addr),
        .xfer_len_i   (xfer_len),
        .cs_n_o       (cs_n),
        .xfer_busy_o  (xfer_busy),
        .xfer_done_o  (xfer_done),
        .xfer_err_o   (xfer_err)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    assign cs_low = ~&cs_n;

    // Run lengths of chip select low and busy, up to the cycle before
    always @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            cs_cnt   <= 0;
            cs_seen  <= 0;
            busy_cnt <= 0;
        end else begin
            cs_cnt   <= cs_low ? cs_cnt + 1 : 0;
            // Select-low cycles within the running transfer
            cs_seen  <= xfer_busy ? cs_seen + int'(cs_low) : 0;
            busy_cnt <= xfer_busy ? busy_cnt + 1 : 0;
        end
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= MaxCycles) begin
            $display("Cycle limit of %0d reached before the tests ended", MaxCycles);
            $display("Simulation FAILED");
            $finish;
        end
    end

    a_ready: assert property (@(posedge clk) disable iff (!arst_n)
        reg_ready == !xfer_busy)
        else begin
            $display("** Error at %0t: reg_ready_o expected %b, got %b",
                     $time, !$sampled(xfer_busy), $sampled(reg_ready));
            assert_errs++;
        end

    a_one_cs: assert property (@(posedge clk) disable iff (!arst_n) $onehot0(~cs_n))
        else begin
            $display("** Error at %0t: cs_n_o has more than one select low, got %b",
                     $time, $sampled(cs_n));
            assert_errs++;
        end

    a_cs_sel: assert property (@(posedge clk) disable iff (!arst_n)
        cs_low |-> (cs_n == ~exp_hit))
        else begin
            $display("** Error at %0t: cs_n_o expected %b, got %b",
                     $time, ~$sampled(exp_hit), $sampled(cs_n));
            assert_errs++;
        end

    a_cs_len: assert property (@(posedge clk) disable iff (!arst_n)
        (!cs_low && cs_cnt != 0) |-> (cs_cnt == exp_cs))
        else begin
            $display("** Error at %0t: cs_n_o low cycles expected %0d, got %0d",
                     $time, $sampled(exp_cs), $sampled(cs_cnt));
            assert_errs++;
        end

    a_cs_total: assert property (@(posedge clk) disable iff (!arst_n)
        xfer_done |-> (cs_seen + int'(cs_low) == (exp_fail ? 0 : exp_cs)))
        else begin
            $display("** Error at %0t: cs_n_o low cycles at done expected %0d, got %0d",
                     $time, $sampled(exp_fail) ? 0 : $sampled(exp_cs),
                     $sampled(cs_seen) + int'($sampled(cs_low)));
            assert_errs++;
        end

    a_done_len: assert property (@(posedge clk) disable iff (!arst_n)
        xfer_done |-> (xfer_busy && busy_cnt + 1 == exp_busy))
        else begin
            $display("** Error at %0t: xfer_busy_o cycles at done expected %0d, got %0d",
                     $time, $sampled(exp_busy), $sampled(busy_cnt) + 1);
            assert_errs++;
        end

    a_err_flag: assert property (@(posedge clk) disable iff (!arst_n)
        xfer_done |-> (xfer_err == exp_fail))
        else begin
            $display("** Error at %0t: xfer_err_o expected %b, got %b",
                     $time, $sampled(exp_fail), $sampled(xfer_err));
            assert_errs++;
        end

    a_err_done: assert property (@(posedge clk) disable iff (!arst_n) xfer_err |-> xfer_done)
        else begin
            $display("** Error at %0t: xfer_done_o expected 1, got 0 with xfer_err_o", $time);
            assert_errs++;
        end

    a_fail_no_cs: assert property (@(posedge clk) disable iff (!arst_n)
        (xfer_busy && exp_fail) |-> !cs_low)
        else begin
            $display("** Error at %0t: cs_n_o expected all high on a rejected request, got %b",
                     $time, $sampled(cs_n));
            assert_errs++;
        end

    function automatic logic [31:0] field_mask(input int idx);
        case (idx)
            0, 3, 4: return 32'h0000_000f;
            1:       return 32'h0000_0001;
            2:       return 32'h0000_00ff;
            default: return 32'hffff_ffff;
        endcase
    endfunction

    // Lowest matching chip wins, end address exclusive
    function automatic logic [NumChips-1:0] model_hit(input logic [31:0] addr);
        logic [NumChips-1:0] hit;
        hit = '0;
        for (int c = NumChips - 1; c >= 0; c--) begin
            if (model_regs[NumBaseRegs + 2 * c] <= addr
                    && addr < model_regs[NumBaseRegs + 2 * c + 1]) begin
                hit    = '0;
                hit[c] = 1'b1;
            end
        end
        return hit;
    endfunction

    task automatic read_check(input int idx);
        @(posedge clk);
        reg_valid <= 1'b1;
        reg_write <= 1'b0;
        reg_addr  <= 8'(idx * 4);
        @(negedge clk);
        assert (reg_rdata == model_regs[idx] && !reg_error)
            else begin
                $display("** Error at %0t: reg_rdata_o[%0d] expected %h, got %h",
                         $time, idx, model_regs[idx], reg_rdata);
                assert_errs++;
            end
    endtask

    task automatic unmapped_check(input int idx);
        @(posedge clk);
        reg_valid <= 1'b1;
        reg_write <= 1'b0;
        reg_addr  <= 8'(idx * 4);
        @(negedge clk);
        assert (reg_error && reg_rdata == 32'h0)
            else begin
                $display("** Error at %0t: reg_error_o/reg_rdata_o expected 1/0, got %b/%h",
                         $time, reg_error, reg_rdata);
                assert_errs++;
            end
    endtask

    // Held until ready; while refused the old value must stay visible
    task automatic reg_write_word(input int idx, input logic [31:0] data,
                                  input logic [3:0] strb, output int refused);
        logic [31:0] m;
        int          n;
        refused = 0;
        n       = 0;
        m       = '0;
        @(posedge clk);
        reg_valid <= 1'b1;
        reg_write <= 1'b1;
        reg_addr  <= 8'(idx * 4);
        reg_wdata <= data;
        reg_wstrb <= strb;
        @(negedge clk);
        while (!reg_ready && n < RegWait) begin
            assert (reg_rdata == model_regs[idx])
                else begin
                    $display("** Error at %0t: reg_rdata_o while refused expected %h, got %h",
                             $time, model_regs[idx], reg_rdata);
                    assert_errs++;
                end
            refused++;
            n++;
            @(negedge clk);
        end
        if (!reg_ready) begin
            $display("Register write to index %0d was never accepted", idx);
            timeout_errs++;
        end
        @(posedge clk);
        reg_valid <= 1'b0;
        reg_write <= 1'b0;
        for (int b = 0; b < 4; b++) begin
            if (strb[b]) begin
                m[8*b +: 8] = 8'hff;
            end
        end
        model_regs[idx] = ((model_regs[idx] & ~m) | (data & m)) & field_mask(idx);
    endtask

    task automatic xfer_start(input logic [31:0] addr, input int len, input bit poke);
        logic [NumChips-1:0] hit;
        int                  lat;
        int                  tail;
        bit                  fail;
        hit  = model_hit(addr);
        fail = (hit == '0) || (len == 0) || (len > int'(model_regs[REG_BURST_MAX]));
        lat  = int'(model_regs[REG_LATENCY]);
        if (model_regs[REG_LAT_ADD][0]) begin
            lat = 2 * lat;
        end
        tail = int'(model_regs[REG_CSH]) + int'(model_regs[REG_RW_RECOVERY]);
        @(posedge clk);
        exp_hit    <= hit;
        exp_fail   <= fail;
        exp_cs     <= int'(CmdCycles) + lat + len;
        exp_busy   <= fail ? 1 : int'(CmdCycles) + lat + len + tail;
        xfer_valid <= 1'b1;
        xfer_write <= 1'($urandom);
        xfer_addr  <= addr;
        xfer_len   <= 8'(len);
        @(posedge clk);
        xfer_valid <= 1'b0;
        // Second request during the command phase must be ignored
        if (poke && !fail) begin
            @(posedge clk);
            xfer_valid <= 1'b1;
            xfer_addr  <= addr ^ 32'h0001_0000;
            xfer_len   <= 8'd1;
            @(posedge clk);
            xfer_valid <= 1'b0;
        end
    endtask

    task automatic wait_done();
        int n;
        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while (!xfer_done && n < XferWait);
        if (!xfer_done) begin
            $display("Transfer did not finish within %0d cycles", XferWait);
            timeout_errs++;
        end
        @(posedge clk);
    endtask

    task automatic xfer_run(input logic [31:0] addr, input int len, input bit poke);
        xfer_start(addr, len, poke);
        wait_done();
    endtask

    initial begin
        int          refused;
        logic [31:0] base;
        logic [31:0] span;
        int          c;
        void'($urandom(32'hccae));
        arst_n       = 1'b0;
        reg_valid    = 1'b0;
        reg_write    = 1'b0;
        reg_addr     = '0;
        reg_wdata    = '0;
        reg_wstrb    = '0;
        xfer_valid   = 1'b0;
        xfer_write   = 1'b0;
        xfer_addr    = '0;
        xfer_len     = '0;
        exp_hit      = '0;
        exp_fail     = 1'b0;
        exp_cs       = 0;
        exp_busy     = 0;
        cycle_cnt    = 0;
        assert_errs  = 0;
        timeout_errs = 0;
        model_regs[REG_LATENCY]     = 32'd6;
        model_regs[REG_LAT_ADD]     = 32'd1;
        model_regs[REG_BURST_MAX]   = 32'd16;
        model_regs[REG_RW_RECOVERY] = 32'd6;
        model_regs[REG_CSH]         = 32'd1;
        for (int i = 0; i < NumChips; i++) begin
            model_regs[NumBaseRegs + 2 * i]     = 32'h10000 * i;
            model_regs[NumBaseRegs + 2 * i + 1] = 32'h10000 * (i + 1);
        end
        repeat (8) @(posedge clk);
        arst_n <= 1'b1;
        @(posedge clk);

        // Reset values
        for (int i = 0; i < NumRegs; i++) begin
            read_check(i);
        end

        // Partial strobes and unmapped indices
        reg_write_word(REG_LATENCY, 32'hffff_fff3, 4'b0001, refused);
        reg_write_word(REG_LATENCY, 32'h0000_0a00, 4'b0010, refused);
        reg_write_word(NumBaseRegs, 32'haabb_ccdd, 4'b0101, refused);
        reg_write_word(REG_BURST_MAX, 32'h1234_5620, 4'b0011, refused);
        for (int i = 0; i < NumRegs; i++) begin
            read_check(i);
        end
        unmapped_check(NumRegs);
        unmapped_check(13);
        unmapped_check(63);
        reg_write_word(NumBaseRegs, 32'h0, 4'hf, refused);

        // Directed transfers with additional latency, then without
        xfer_run(32'h0000_0100, 4, 1'b0);
        xfer_run(32'h0001_0010, 8, 1'b1);
        xfer_run(32'h0002_0000, 4, 1'b0);
        xfer_run(32'h0000_0100, 0, 1'b0);
        xfer_run(32'h0000_0100, 33, 1'b0);
        reg_write_word(REG_LAT_ADD, 32'h0, 4'hf, refused);
        xfer_run(32'h0001_0004, 5, 1'b0);
        xfer_run(32'h0000_ffff, 1, 1'b1);
        reg_write_word(REG_CSH, 32'h0, 4'hf, refused);
        reg_write_word(REG_RW_RECOVERY, 32'h0, 4'hf, refused);
        xfer_run(32'h0000_0020, 2, 1'b0);
        reg_write_word(REG_CSH, 32'h2, 4'hf, refused);
        reg_write_word(REG_RW_RECOVERY, 32'h3, 4'hf, refused);

        // Register write during a transfer waits for the end of busy
        xfer_start(32'h0000_0200, 10, 1'b0);
        reg_write_word(REG_CSH, 32'h7, 4'hf, refused);
        if (refused == 0) begin
            $display("Register write during a transfer was accepted while busy");
            assert_errs++;
        end
        read_check(REG_CSH);

        // Random rounds
        for (int r = 0; r < 12; r++) begin
            for (int i = 0; i < NumChips; i++) begin
                base = $urandom % 1024;
                span = 16 + $urandom % 256;
                reg_write_word(NumBaseRegs + 2 * i, base, 4'hf, refused);
                reg_write_word(NumBaseRegs + 2 * i + 1, base + span, 4'hf, refused);
            end
            reg_write_word(REG_LATENCY, $urandom, 4'hf, refused);
            reg_write_word(REG_LAT_ADD, $urandom, 4'hf, refused);
            reg_write_word(REG_BURST_MAX, $urandom % 48, 4'hf, refused);
            reg_write_word(REG_RW_RECOVERY, $urandom, 4'hf, refused);
            reg_write_word(REG_CSH, $urandom, 4'hf, refused);
            for (int i = 0; i < NumRegs; i++) begin
                read_check(i);
            end
            for (int t = 0; t < 4; t++) begin
                c    = int'($urandom % NumChips);
                base = model_regs[NumBaseRegs + 2 * c];
                span = model_regs[NumBaseRegs + 2 * c + 1] - base;
                xfer_run(base + ($urandom % (span + 8)) - 32'd4,
                         int'($urandom % (model_regs[REG_BURST_MAX] + 2)),
                         1'($urandom));
            end
        end

        repeat (4) @(posedge clk);
        $display("Error count: %0d check errors, %0d timeouts", assert_errs, timeout_errs);
        if (assert_errs == 0 && timeout_errs == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

//--- hyper_cfg.f
rtl/hyper_cfg_pkg.sv
rtl/hyper_xfer_pkg.sv
rtl/hyper_cfg_regs.sv
rtl/hyper_chip_decoder.sv
rtl/hyper_xfer_ctrl.sv
rtl/hyper_cfg_top.sv
dv/tb_hyper_cfg.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the HyperBus configuration testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_hyper_cfg -f hyper_cfg.f -o sim_hyper_cfg

./obj_dir/sim_hyper_cfg | tee sim.log

if grep -q "Simulation FAILED" sim.log; then
    echo "run_sim: failures reported, see sim.log"
    exit 1
fi
if ! grep -q "Simulation PASSED" sim.log; then
    echo "run_sim: no result line found in sim.log"
    exit 1
fi
echo "run_sim: done"
